// ==== ntt_butterfly.sv ====
`timescale 1ns/10ps

module ntt_butterfly import ntt_pkg::*; (
    input  coef_t a,
    input  coef_t b,
    input  coef_t w,
    input  coef_t q,
    output coef_t sum,
    output coef_t diff
);

    logic [2*COEF_W-1:0] prod;
    logic [2*COEF_W-1:0] prod_red;
    coef_t               wb;
    logic [COEF_W:0]     sum_raw;
    logic [COEF_W:0]     sum_red;

    // full product before reduction
    assign prod = {{COEF_W{1'b0}}, w} * {{COEF_W{1'b0}}, b};

    // empty pipeline slots carry a zero modulus
    assign prod_red = (q == '0) ? '0 : prod % {{COEF_W{1'b0}}, q};

    // w*b mod q is below q, so it fits a residue
    assign wb = prod_red[COEF_W-1:0];

    // a + wb is below 2q, one subtraction is enough
    assign sum_raw = {1'b0, a} + {1'b0, wb};
    assign sum_red = (sum_raw >= {1'b0, q}) ? sum_raw - {1'b0, q} : sum_raw;
    assign sum     = sum_red[COEF_W-1:0];

    // negative difference wraps by adding q back
    assign diff = (a >= wb) ? a - wb : a + (q - wb);

endmodule

// ==== ntt_pkg.sv ====
package ntt_pkg;

    // residue width, shared by coefficients, twiddles and the modulus
    localparam int COEF_W   = 16;

    // one radix-16 job
    localparam int N_POINTS = 16;
    localparam int N_BFLY   = N_POINTS / 2;

    // radix-2 stages, one register each
    localparam int N_STAGES = 4;

    // memory index carried in the tag
    localparam int IDX_W    = 6;

    typedef logic [COEF_W-1:0] coef_t;

    typedef logic [IDX_W-1:0] idx_t;

    // coefficients in natural order, element i is position i
    typedef coef_t [N_POINTS-1:0] ntt_vec_t;

    // modulus and twiddle table, twiddle 0 never selected
    typedef struct packed {
        coef_t    modulus;
        ntt_vec_t twiddle;
    } ntt_ctx_t;

    // read/write indices that return with the result
    typedef struct packed {
        idx_t [N_POINTS-1:0] ma_idx;
        idx_t [N_POINTS-1:0] bn_idx;
    } ntt_tag_t;

endpackage

// ==== ntt_r16_asserts.sv ====
`timescale 1ns/10ps

module ntt_r16_asserts import ntt_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     out_valid,
    input logic     tag_valid,
    input ntt_vec_t out_data
);

    // tag_valid is in_valid delayed by the pipeline depth
    property p_valid_latency;
        @(posedge clk) disable iff (rst) out_valid == tag_valid;
    endproperty

    property p_valid_low_in_reset;
        @(posedge clk) rst |-> !out_valid;
    endproperty

    // first edge after reset release
    property p_valid_low_after_reset;
        @(posedge clk) $fell(rst) |-> !out_valid;
    endproperty

    property p_data_known;
        @(posedge clk) disable iff (rst) out_valid |-> !$isunknown(out_data);
    endproperty

    a_valid_latency: assert property (p_valid_latency)
        else $error("out_valid differs from in_valid four cycles earlier");

    a_valid_low_in_reset: assert property (p_valid_low_in_reset)
        else $error("out_valid high during reset");

    a_valid_low_after_reset: assert property (p_valid_low_after_reset)
        else $error("out_valid high on the cycle after reset");

    a_data_known: assert property (p_data_known)
        else $error("out_data has unknown bits while out_valid is high");

endmodule

bind ntt_r16_core ntt_r16_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .tag_valid (tag_valid),
    .out_data  (out_data)
);

// ==== ntt_r16_core.sv ====
`timescale 1ns/10ps

module ntt_r16_core import ntt_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  ntt_vec_t in_data,
    input  ntt_ctx_t in_ctx,
    input  ntt_tag_t in_tag,
    output logic     out_valid,
    output ntt_vec_t out_data,
    output ntt_tag_t out_tag
);

    // stage 0 to 1
    logic     s0_valid;
    ntt_vec_t s0_data;
    ntt_ctx_t s0_ctx;

    // stage 1 to 2
    logic     s1_valid;
    ntt_vec_t s1_data;
    ntt_ctx_t s1_ctx;

    // stage 2 to 3
    logic     s2_valid;
    ntt_vec_t s2_data;
    ntt_ctx_t s2_ctx;

    // delayed copy of in_valid, checked against out_valid
    logic     tag_valid;

    // span 8, twiddle 1
    ntt_stage #(.STAGE(0)) u_stage0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ctx    (in_ctx),
        .out_valid (s0_valid),
        .out_data  (s0_data),
        .out_ctx   (s0_ctx)
    );

    // span 4, twiddles 2 and 3
    ntt_stage #(.STAGE(1)) u_stage1 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s0_valid),
        .in_data   (s0_data),
        .in_ctx    (s0_ctx),
        .out_valid (s1_valid),
        .out_data  (s1_data),
        .out_ctx   (s1_ctx)
    );

    // span 2, twiddles 4 to 7
    ntt_stage #(.STAGE(2)) u_stage2 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s1_valid),
        .in_data   (s1_data),
        .in_ctx    (s1_ctx),
        .out_valid (s2_valid),
        .out_data  (s2_data),
        .out_ctx   (s2_ctx)
    );

    // span 1, twiddles 8 to 15, context not needed past here
    ntt_stage #(.STAGE(3)) u_stage3 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s2_valid),
        .in_data   (s2_data),
        .in_ctx    (s2_ctx),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ctx   ()
    );

    // tag rides N_STAGES cycles beside its job
    ntt_tag_delay u_tag_delay (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_tag    (in_tag),
        .out_valid (tag_valid),
        .out_tag   (out_tag)
    );

endmodule

// ==== ntt_stage.sv ====
`timescale 1ns/10ps

module ntt_stage import ntt_pkg::*; #(
    parameter int STAGE = 0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  ntt_vec_t in_data,
    input  ntt_ctx_t in_ctx,
    output logic     out_valid,
    output ntt_vec_t out_data,
    output ntt_ctx_t out_ctx
);

    // distance between the two inputs of a butterfly
    localparam int HALF = N_BFLY >> STAGE;

    // position bit that separates the upper and lower input
    localparam int SPLIT_BIT = N_STAGES - 1 - STAGE;

    // butterfly results, still in place
    ntt_vec_t bfly_data;

    genvar k;
    generate
        for (k = 0; k < N_BFLY; k++) begin : g_bfly
            // k-th position with a zero split bit, and its partner
            localparam int POS_A = ((k >> SPLIT_BIT) << (SPLIT_BIT + 1)) | (k % HALF);
            localparam int POS_B = POS_A + HALF;

            // one twiddle per group of butterflies
            localparam int TW_IDX = (1 << STAGE) + (POS_A >> (N_STAGES - STAGE));

            ntt_butterfly u_bfly (
                .a    (in_data[POS_A]),
                .b    (in_data[POS_B]),
                .w    (in_ctx.twiddle[TW_IDX]),
                .q    (in_ctx.modulus),
                .sum  (bfly_data[POS_A]),
                .diff (bfly_data[POS_B])
            );
        end
    endgenerate

    // valid follows every cycle so gaps stay in place
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload and context only load with a job
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_data <= '0;
            out_ctx  <= '0;
        end else if (in_valid) begin
            out_data <= bfly_data;
            out_ctx  <= in_ctx;
        end
    end

endmodule

// ==== ntt_tag_delay.sv ====
`timescale 1ns/10ps

module ntt_tag_delay import ntt_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  ntt_tag_t in_tag,
    output logic     out_valid,
    output ntt_tag_t out_tag
);

    // one slot per stage register, slot 0 is the newest job
    logic [N_STAGES-1:0] valid_sr;
    ntt_tag_t            tag_sr [N_STAGES];

    // shifts every cycle, so a slot lines up with its stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_sr <= '0;
            for (int i = 0; i < N_STAGES; i++) begin
                tag_sr[i] <= '0;
            end
        end else begin
            valid_sr <= {valid_sr[N_STAGES-2:0], in_valid};
            tag_sr[0] <= in_tag;
            for (int i = 1; i < N_STAGES; i++) begin
                tag_sr[i] <= tag_sr[i-1];
            end
        end
    end

    // oldest slot leaves with the last stage
    assign out_valid = valid_sr[N_STAGES-1];
    assign out_tag   = tag_sr[N_STAGES-1];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the NTT testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

top=tb_ntt_r16
build_dir=obj_dir
build_log=build.log
sim_log=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -f sim.f --top-module "$top" \
    -Mdir "$build_dir" -o "$top" > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "build failed with status $status"
    exit 1
fi

"./$build_dir/$top" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx "SIMULATION PASSED" "$sim_log"; then
    exit 0
fi

echo "pass message not found in $sim_log"
exit 1

// ==== sim.f ====
ntt_pkg.sv
ntt_butterfly.sv
ntt_stage.sv
ntt_tag_delay.sv
ntt_r16_core.sv
ntt_r16_asserts.sv
tb_ntt_r16.sv

// ==== tb_ntt_r16.sv ====
`timescale 1ns/10ps

module tb_ntt_r16 import ntt_pkg::*; ();

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 2;
    localparam int IDLE_CYCLES  = 2;
    localparam int N_ENTRIES    = 8;

    // stimulus patterns
    localparam int PAT_RANDOM  = 0;
    localparam int PAT_ZERO_TW = 1;
    localparam int PAT_MAX     = 2;
    localparam int PAT_GAP     = 3;

    // PAT_GAP entries send random data and then one idle cycle
    localparam int unsigned TBL_MOD [N_ENTRIES] = '{
        3329, 7681, 12289, 65521, 3329, 65521, 7681, 3329
    };
    localparam int TBL_PAT [N_ENTRIES] = '{
        PAT_RANDOM, PAT_GAP, PAT_RANDOM, PAT_RANDOM,
        PAT_ZERO_TW, PAT_MAX, PAT_GAP, PAT_MAX
    };

    logic     clk;
    logic     rst;
    logic     in_valid;
    ntt_vec_t in_data;
    ntt_ctx_t in_ctx;
    ntt_tag_t in_tag;
    logic     out_valid;
    ntt_vec_t out_data;
    ntt_tag_t out_tag;

    logic [31:0]         lfsr_state;
    ntt_vec_t            exp_data_q [$];
    ntt_tag_t            exp_tag_q [$];
    logic [N_STAGES-1:0] valid_hist;
    int                  cycle_cnt;
    int                  max_cycles;
    ntt_vec_t            job_data;
    ntt_ctx_t            job_ctx;
    ntt_tag_t            job_tag;

    ntt_r16_core uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ctx    (in_ctx),
        .in_tag    (in_tag),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_tag   (out_tag)
    );

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    // one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits = {bits[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return bits;
    endfunction

    function automatic coef_t rand_residue(input int unsigned q);
        logic [31:0] r;
        r = take_bits(COEF_W);
        return coef_t'(r % q);
    endfunction

    function automatic int count_gaps();
        int n;
        n = 0;
        for (int e = 0; e < N_ENTRIES; e++) begin
            if (TBL_PAT[e] == PAT_GAP) begin
                n++;
            end
        end
        return n;
    endfunction

    // four radix-2 stages done in place
    function automatic ntt_vec_t model_ntt(input ntt_vec_t x, input ntt_ctx_t c);
        ntt_vec_t v;
        int       h;
        longint   q;
        longint   a;
        longint   b;
        longint   w;
        longint   t;
        v = x;
        q = longint'(c.modulus);
        for (int s = 0; s < N_STAGES; s++) begin
            h = 8 >> s;
            for (int i = 0; i < N_POINTS; i++) begin
                if (((i >> (3 - s)) & 1) == 0) begin
                    a = longint'(v[i]);
                    b = longint'(v[i + h]);
                    w = longint'(c.twiddle[(1 << s) + (i >> (4 - s))]);
                    t = (w * b) % q;
                    v[i]     = coef_t'((a + t) % q);
                    v[i + h] = coef_t'((a - t + q) % q);
                end
            end
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic make_job(input int e);
        int unsigned q;
        q = TBL_MOD[e];
        job_ctx.modulus = coef_t'(q);
        for (int i = 0; i < N_POINTS; i++) begin
            case (TBL_PAT[e])
                PAT_MAX: begin
                    job_data[i]        = coef_t'(q - 1);
                    job_ctx.twiddle[i] = coef_t'(q - 1);
                end
                PAT_ZERO_TW: begin
                    job_data[i]        = rand_residue(q);
                    job_ctx.twiddle[i] = '0;
                end
                default: begin
                    job_data[i]        = rand_residue(q);
                    job_ctx.twiddle[i] = rand_residue(q);
                end
            endcase
            job_tag.ma_idx[i] = idx_t'(take_bits(IDX_W));
            job_tag.bn_idx[i] = idx_t'(take_bits(IDX_W));
        end
    endtask

    task automatic send_job(input int e);
        make_job(e);
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= job_data;
        in_ctx   <= job_ctx;
        in_tag   <= job_tag;
        exp_data_q.push_back(model_ntt(job_data, job_ctx));
        exp_tag_q.push_back(job_tag);
    endtask

    task automatic send_idle();
        @(posedge clk);
        in_valid <= 1'b0;
        in_tag   <= '0;
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout after %0d cycles, results did not all arrive", cycle_cnt);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    // outputs settle by the falling edge
    always @(negedge clk) begin
        check_value("out_valid", 256'(out_valid), 256'(valid_hist[N_STAGES-1]));
        if (out_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("result came out with no job in flight");
                $display("SIMULATION FAILED");
                $fatal(1, "unexpected result");
            end
            check_value("out_data", 256'(out_data), 256'(exp_data_q.pop_front()));
            check_value("out_tag", 256'(out_tag), 256'(exp_tag_q.pop_front()));
        end
        valid_hist <= {valid_hist[N_STAGES-2:0], in_valid};
    end

    initial begin
        lfsr_state = 32'hec1a;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        in_ctx     = '0;
        in_tag     = '0;
        valid_hist = '0;
        cycle_cnt  = 0;
        max_cycles = 2 * (2 * N_ENTRIES + count_gaps() + N_STAGES + RESET_CYCLES
                          + IDLE_CYCLES);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // quiet outputs before the first job
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("out_valid", 256'(out_valid), '0);
            check_value("out_data", 256'(out_data), '0);
            check_value("out_tag", 256'(out_tag), '0);
        end

        // first pass keeps the gaps
        for (int e = 0; e < N_ENTRIES; e++) begin
            send_job(e);
            if (TBL_PAT[e] == PAT_GAP) begin
                send_idle();
            end
        end
        // second pass back to back with four jobs in flight
        for (int e = 0; e < N_ENTRIES; e++) begin
            send_job(e);
        end
        send_idle();

        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(negedge clk);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
